//--- logic/lc4_params.svh
// LC4 pipeline parameters
// word and register sizes, reset PC and the ISA encodings used by the core
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

`define LC4_WORD_W   16         // data and instruction width
`define LC4_NREG     8          // r0..r7
`define LC4_RSEL_W   3          // register select width
`define LC4_RESET_PC 16'h8200   // first fetch address after reset

// major opcodes in insn[15:12]
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

// sub-opcodes in insn[5:3], register form only
`define LC4_SUB_ADD  3'b000
`define LC4_SUB_SUB  3'b010
`define LC4_SUB_AND  3'b000
`define LC4_SUB_NOT  3'b001
`define LC4_SUB_OR   3'b010
`define LC4_SUB_XOR  3'b011

// condition codes, one-hot
`define LC4_NZP_NEG  3'b100
`define LC4_NZP_ZERO 3'b010
`define LC4_NZP_POS  3'b001

`endif

//--- logic/lc4_isa_pkg.sv
// LC4 instruction formats
// one 16-bit word seen either as register form or as immediate form
`include "lc4_params.svh"

package lc4_isa_pkg;

   // rd = rs op rt
   typedef struct packed {
      logic [3:0]             opcode;
      logic [`LC4_RSEL_W-1:0] rd;
      logic [`LC4_RSEL_W-1:0] rs;
      logic [2:0]             subop;    // top bit overlaps imm_flag
      logic [`LC4_RSEL_W-1:0] rt;
   } lc4_rtype_s;

   // rd = rs op imm5
   // CONST imm9 and STR imm6 are sliced out of this view as well
   typedef struct packed {
      logic [3:0]             opcode;
      logic [`LC4_RSEL_W-1:0] rd;       // STR data source lives here
      logic [`LC4_RSEL_W-1:0] rs;
      logic                   imm_flag; // insn[5], picks ADD/AND imm form
      logic [4:0]             imm5;
   } lc4_itype_s;

   // bit 5 decides which view is the real one for ADD and AND
   typedef union packed {
      lc4_rtype_s r;
      lc4_itype_s i;
   } lc4_insn_u;

endpackage

//--- logic/lc4_decoder.sv
// LC4 instruction decoder
// register selects and enables for the supported subset
// anything outside the subset decodes to a no-op
`include "lc4_params.svh"

module lc4_decoder (
   input  lc4_isa_pkg::lc4_insn_u       i_insn,
   output logic [`LC4_RSEL_W-1:0]       o_rs_sel,
   output logic [`LC4_RSEL_W-1:0]       o_rt_sel,
   output logic [`LC4_RSEL_W-1:0]       o_rd_sel,
   output logic                         o_rs_re,
   output logic                         o_rt_re,
   output logic                         o_rf_we,
   output logic                         o_nzp_we,
   output logic                         o_is_store
);
   import lc4_isa_pkg::*;

   lc4_rtype_s rv;    // register view
   lc4_itype_s iv;    // immediate view
   logic       wr_op; // writes rd, and nzp with it

   assign rv = i_insn.r;
   assign iv = i_insn.i;

   // fields sit in fixed places, STR moves its data source up to [11:9]
   assign o_rs_sel = rv.rs;
   assign o_rd_sel = rv.rd;
   assign o_rt_sel = (rv.opcode == `LC4_OP_STR) ? iv.rd : rv.rt;

   always_comb begin
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      wr_op      = 1'b0;
      o_is_store = 1'b0;
      case (rv.opcode)
         `LC4_OP_ARITH: begin
            if (iv.imm_flag) begin            // ADD imm5
               o_rs_re = 1'b1;
               wr_op   = 1'b1;
            end else if ((rv.subop == `LC4_SUB_ADD) || (rv.subop == `LC4_SUB_SUB)) begin
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               wr_op   = 1'b1;
            end                               // MUL, DIV fall through as no-op
         end
         `LC4_OP_LOGIC: begin
            if (iv.imm_flag) begin            // AND imm5
               o_rs_re = 1'b1;
               wr_op   = 1'b1;
            end else begin
               case (rv.subop)
                  `LC4_SUB_AND, `LC4_SUB_OR, `LC4_SUB_XOR: begin
                     o_rs_re = 1'b1;
                     o_rt_re = 1'b1;
                     wr_op   = 1'b1;
                  end
                  `LC4_SUB_NOT: begin         // single source
                     o_rs_re = 1'b1;
                     wr_op   = 1'b1;
                  end
                  default: ;
               endcase
            end
         end
         `LC4_OP_CONST: wr_op = 1'b1;         // no sources
         `LC4_OP_STR: begin                   // address from rs, data from rt
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_is_store = 1'b1;
         end
         default: ;                           // unsupported, all enables low
      endcase
   end

   assign o_rf_we  = wr_op;
   assign o_nzp_we = wr_op; // every register write sets nzp

endmodule

//--- logic/lc4_regfile.sv
// LC4 register file
// eight words, two combinational reads, one write on gwe
// a read of the register being written returns the write data (WD bypass)
`include "lc4_params.svh"

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  logic [`LC4_RSEL_W-1:0] i_rs_sel,
   input  logic [`LC4_RSEL_W-1:0] i_rt_sel,
   input  logic                   i_rs_re,
   input  logic                   i_rt_re,
   input  logic [`LC4_RSEL_W-1:0] i_rd_sel,
   input  logic                   i_rd_we,
   input  logic [`LC4_WORD_W-1:0] i_wdata,
   output logic [`LC4_WORD_W-1:0] o_rs_data,
   output logic [`LC4_WORD_W-1:0] o_rt_data
);

   logic [`LC4_WORD_W-1:0] regs [`LC4_NREG];
   logic                   wd_rs; // rs read hits the writeback
   logic                   wd_rt;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `LC4_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // only bypass when the port is actually read
   assign wd_rs = i_rd_we && i_rs_re && (i_rd_sel == i_rs_sel);
   assign wd_rt = i_rd_we && i_rt_re && (i_rd_sel == i_rt_sel);

   assign o_rs_data = wd_rs ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = wd_rt ? i_wdata : regs[i_rt_sel];

endmodule

//--- logic/lc4_execute.sv
// LC4 execute stage
// MX and WX operand bypass in front of the ALU
// also forms the STR address and passes the bypassed store data on
`include "lc4_params.svh"

module lc4_execute (
   input  lc4_isa_pkg::lc4_insn_u       i_insn,
   input  logic [`LC4_RSEL_W-1:0]       i_rs_sel,
   input  logic [`LC4_RSEL_W-1:0]       i_rt_sel,
   input  logic                         i_rs_re,
   input  logic                         i_rt_re,
   input  logic [`LC4_WORD_W-1:0]       i_rs_data,
   input  logic [`LC4_WORD_W-1:0]       i_rt_data,
   input  logic [`LC4_RSEL_W-1:0]       i_m_rd_sel,
   input  logic                         i_m_rf_we,
   input  logic [`LC4_WORD_W-1:0]       i_m_result,
   input  logic [`LC4_RSEL_W-1:0]       i_w_rd_sel,
   input  logic                         i_w_rf_we,
   input  logic [`LC4_WORD_W-1:0]       i_w_result,
   output logic [`LC4_WORD_W-1:0]       o_result,
   output logic [`LC4_WORD_W-1:0]       o_store_data
);
   import lc4_isa_pkg::*;

   lc4_rtype_s             rv;
   lc4_itype_s             iv;
   logic                   mx_rs;   // M writes our rs
   logic                   mx_rt;
   logic                   wx_rs;   // W writes our rs
   logic                   wx_rt;
   logic [`LC4_WORD_W-1:0] rs_val;  // operands after bypass
   logic [`LC4_WORD_W-1:0] rt_val;
   logic [`LC4_WORD_W-1:0] imm5_sx;
   logic [`LC4_WORD_W-1:0] imm6_sx;
   logic [`LC4_WORD_W-1:0] imm9_sx;

   assign rv = i_insn.r;
   assign iv = i_insn.i;

   assign mx_rs = i_m_rf_we && i_rs_re && (i_m_rd_sel == i_rs_sel);
   assign mx_rt = i_m_rf_we && i_rt_re && (i_m_rd_sel == i_rt_sel);
   assign wx_rs = i_w_rf_we && i_rs_re && (i_w_rd_sel == i_rs_sel);
   assign wx_rt = i_w_rf_we && i_rt_re && (i_w_rd_sel == i_rt_sel);

   // M is the younger producer, so it wins over W
   assign rs_val = mx_rs ? i_m_result : (wx_rs ? i_w_result : i_rs_data);
   assign rt_val = mx_rt ? i_m_result : (wx_rt ? i_w_result : i_rt_data);

   // immediates, all sign extended
   assign imm5_sx = {{(`LC4_WORD_W-5){iv.imm5[4]}}, iv.imm5};
   assign imm6_sx = {{(`LC4_WORD_W-6){iv.imm_flag}}, iv.imm_flag, iv.imm5};
   assign imm9_sx = {{(`LC4_WORD_W-9){iv.rs[2]}}, iv.rs, iv.imm_flag, iv.imm5};

   always_comb begin
      o_result = '0; // no-ops leave zero, nothing consumes it
      case (rv.opcode)
         `LC4_OP_ARITH: begin
            if (iv.imm_flag) begin
               o_result = rs_val + imm5_sx;
            end else begin
               case (rv.subop)
                  `LC4_SUB_ADD: o_result = rs_val + rt_val;
                  `LC4_SUB_SUB: o_result = rs_val - rt_val;
                  default:      o_result = '0;
               endcase
            end
         end
         `LC4_OP_LOGIC: begin
            if (iv.imm_flag) begin
               o_result = rs_val & imm5_sx;
            end else begin
               case (rv.subop)
                  `LC4_SUB_AND: o_result = rs_val & rt_val;
                  `LC4_SUB_NOT: o_result = ~rs_val;
                  `LC4_SUB_OR:  o_result = rs_val | rt_val;
                  `LC4_SUB_XOR: o_result = rs_val ^ rt_val;
                  default:      o_result = '0;
               endcase
            end
         end
         `LC4_OP_CONST: o_result = imm9_sx;
         `LC4_OP_STR:   o_result = rs_val + imm6_sx;   // effective address
         default:       o_result = '0;
      endcase
   end

   // store data needs the same bypass as the ALU inputs
   assign o_store_data = rt_val;

endmodule

//--- logic/lc4_processor.sv
// LC4 five-stage pipeline, fetch/decode/execute/memory/writeback
// no branches and no stalls, PC steps by one every cycle
// MX, WX and WD bypass, NZP update in writeback, retire trace outputs
`include "lc4_params.svh"

module lc4_processor (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   output logic [`LC4_WORD_W-1:0] o_imem_addr,
   input  logic [`LC4_WORD_W-1:0] i_imem_insn,   // combinational reply to o_imem_addr
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic [`LC4_WORD_W-1:0] o_dmem_wdata,
   output logic                   o_wb_stall,
   output logic [`LC4_WORD_W-1:0] o_wb_pc,
   output logic [`LC4_WORD_W-1:0] o_wb_insn,
   output logic                   o_wb_rf_we,
   output logic [`LC4_RSEL_W-1:0] o_wb_rf_wsel,
   output logic [`LC4_WORD_W-1:0] o_wb_rf_data,
   output logic                   o_wb_nzp_we,
   output logic [2:0]             o_wb_nzp
);
   import lc4_isa_pkg::*;

   // fetch
   logic [`LC4_WORD_W-1:0] f_pc;

   // decode
   logic [`LC4_WORD_W-1:0] d_pc;
   lc4_insn_u              d_insn;
   logic [`LC4_RSEL_W-1:0] d_rs_sel;
   logic [`LC4_RSEL_W-1:0] d_rt_sel;
   logic [`LC4_RSEL_W-1:0] d_rd_sel;
   logic                   d_rs_re;
   logic                   d_rt_re;
   logic                   d_rf_we;
   logic                   d_nzp_we;
   logic                   d_is_store;
   logic [`LC4_WORD_W-1:0] d_rs_data;     // already WD bypassed
   logic [`LC4_WORD_W-1:0] d_rt_data;

   // execute
   logic [`LC4_WORD_W-1:0] x_pc;
   lc4_insn_u              x_insn;
   logic [`LC4_RSEL_W-1:0] x_rs_sel;
   logic [`LC4_RSEL_W-1:0] x_rt_sel;
   logic [`LC4_RSEL_W-1:0] x_rd_sel;
   logic                   x_rs_re;
   logic                   x_rt_re;
   logic                   x_rf_we;
   logic                   x_nzp_we;
   logic                   x_is_store;
   logic [`LC4_WORD_W-1:0] x_rs_data;
   logic [`LC4_WORD_W-1:0] x_rt_data;
   logic [`LC4_WORD_W-1:0] x_result;
   logic [`LC4_WORD_W-1:0] x_store_data;

   // memory
   logic [`LC4_WORD_W-1:0] m_pc;
   logic [`LC4_WORD_W-1:0] m_insn;
   logic [`LC4_RSEL_W-1:0] m_rd_sel;
   logic                   m_rf_we;
   logic                   m_nzp_we;
   logic                   m_is_store;
   logic [`LC4_WORD_W-1:0] m_result;      // ALU value or store address
   logic [`LC4_WORD_W-1:0] m_store_data;

   // writeback
   logic [`LC4_WORD_W-1:0] w_pc;
   logic [`LC4_WORD_W-1:0] w_insn;
   logic [`LC4_RSEL_W-1:0] w_rd_sel;
   logic                   w_rf_we;
   logic                   w_nzp_we;
   logic [`LC4_WORD_W-1:0] w_result;
   logic [2:0]             w_nzp_new;     // sign of w_result
   logic [2:0]             nzp_q;

   // PC, straight-line only
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         f_pc <= `LC4_RESET_PC;
      end else begin
         f_pc <= f_pc + 1'b1;
      end
   end

   assign o_imem_addr = f_pc;

   lc4_decoder u_decoder (
      .i_insn     (d_insn),
      .o_rs_sel   (d_rs_sel),
      .o_rt_sel   (d_rt_sel),
      .o_rd_sel   (d_rd_sel),
      .o_rs_re    (d_rs_re),
      .o_rt_re    (d_rt_re),
      .o_rf_we    (d_rf_we),
      .o_nzp_we   (d_nzp_we),
      .o_is_store (d_is_store)
   );

   // written from W, read by D
   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (d_rs_sel),
      .i_rt_sel  (d_rt_sel),
      .i_rs_re   (d_rs_re),
      .i_rt_re   (d_rt_re),
      .i_rd_sel  (w_rd_sel),
      .i_rd_we   (w_rf_we),
      .i_wdata   (w_result),
      .o_rs_data (d_rs_data),
      .o_rt_data (d_rt_data)
   );

   lc4_execute u_execute (
      .i_insn       (x_insn),
      .i_rs_sel     (x_rs_sel),
      .i_rt_sel     (x_rt_sel),
      .i_rs_re      (x_rs_re),
      .i_rt_re      (x_rt_re),
      .i_rs_data    (x_rs_data),
      .i_rt_data    (x_rt_data),
      .i_m_rd_sel   (m_rd_sel),
      .i_m_rf_we    (m_rf_we),
      .i_m_result   (m_result),
      .i_w_rd_sel   (w_rd_sel),
      .i_w_rf_we    (w_rf_we),
      .i_w_result   (w_result),
      .o_result     (x_result),
      .o_store_data (x_store_data)
   );

   // instruction words and control bits, reset to a bubble (0000h)
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         d_insn     <= '0;
         x_insn     <= '0;
         x_rs_re    <= 1'b0;
         x_rt_re    <= 1'b0;
         x_rf_we    <= 1'b0;
         x_nzp_we   <= 1'b0;
         x_is_store <= 1'b0;
         m_insn     <= '0;
         m_rf_we    <= 1'b0;
         m_nzp_we   <= 1'b0;
         m_is_store <= 1'b0;
         w_insn     <= '0;
         w_rf_we    <= 1'b0;
         w_nzp_we   <= 1'b0;
      end else begin
         d_insn     <= i_imem_insn;
         x_insn     <= d_insn;
         x_rs_re    <= d_rs_re;
         x_rt_re    <= d_rt_re;
         x_rf_we    <= d_rf_we;
         x_nzp_we   <= d_nzp_we;
         x_is_store <= d_is_store;
         m_insn     <= x_insn;
         m_rf_we    <= x_rf_we;
         m_nzp_we   <= x_nzp_we;
         m_is_store <= x_is_store;
         w_insn     <= m_insn;
         w_rf_we    <= m_rf_we;
         w_nzp_we   <= m_nzp_we;
      end
   end

   // payload, only meaningful alongside its enables
   always_ff @(posedge gwe) begin
      d_pc         <= f_pc;
      x_pc         <= d_pc;
      x_rs_sel     <= d_rs_sel;
      x_rt_sel     <= d_rt_sel;
      x_rd_sel     <= d_rd_sel;
      x_rs_data    <= d_rs_data;
      x_rt_data    <= d_rt_data;
      m_pc         <= x_pc;
      m_rd_sel     <= x_rd_sel;
      m_result     <= x_result;
      m_store_data <= x_store_data;
      w_pc         <= m_pc;
      w_rd_sel     <= m_rd_sel;
      w_result     <= m_result;
   end

   // data memory port, write only
   assign o_dmem_we    = m_is_store;
   assign o_dmem_addr  = m_result;
   assign o_dmem_wdata = m_store_data;

   // condition codes from the value being written back
   assign w_nzp_new = w_result[`LC4_WORD_W-1] ? `LC4_NZP_NEG :
                      (w_result == '0)        ? `LC4_NZP_ZERO : `LC4_NZP_POS;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp_q <= '0;
      end else if (w_nzp_we) begin
         nzp_q <= w_nzp_new;
      end
   end

   // retire trace
   assign o_wb_stall   = (w_insn == '0);                  // bubble or reset fill
   assign o_wb_pc      = w_pc;
   assign o_wb_insn    = w_insn;
   assign o_wb_rf_we   = w_rf_we;
   assign o_wb_rf_wsel = w_rd_sel;
   assign o_wb_rf_data = w_result;
   assign o_wb_nzp_we  = w_nzp_we;
   assign o_wb_nzp     = w_nzp_we ? w_nzp_new : nzp_q;    // held value when not written

endmodule

//--- verif/lc4_clkgen.sv
// LC4 testbench clock and reset source
// gwe with period 10, i_rst_n held low for the first 8 rising edges
module lc4_clkgen (
   output logic gwe,
   output logic o_rst_n
);

   initial begin
      gwe = 1'b0;
      forever #5 gwe = ~gwe;   // period 10
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (8) @(posedge gwe);
      #1 o_rst_n = 1'b1;       // released just after the edge, like the other inputs
   end

endmodule

//--- verif/lc4_pipe_assert.sv
// LC4 pipeline protocol checks bound onto lc4_processor
// the dmem enable stays known, bubbles never write and the fetch address steps by one
`include "lc4_params.svh"

module lc4_pipe_assert (
   input logic                   gwe,
   input logic                   i_rst_n,
   input logic [`LC4_WORD_W-1:0] i_imem_addr,
   input logic                   i_dmem_we,
   input logic                   i_wb_stall,
   input logic                   i_wb_rf_we,
   input logic                   i_wb_nzp_we
);

   int n_fail = 0;   // failed assertions so far

   // store enable must be a clean 0 or 1 once out of reset
   property p_dmem_we_known;
      @(posedge gwe) disable iff (!i_rst_n) !$isunknown(i_dmem_we);
   endproperty

   // a bubble in writeback never touches the regfile or nzp
   property p_no_write_on_stall;
      @(posedge gwe) disable iff (!i_rst_n) i_wb_stall |-> (!i_wb_rf_we && !i_wb_nzp_we);
   endproperty

   // straight-line fetch where $past skips the first edge after release
   property p_pc_steps;
      @(posedge gwe) disable iff (!i_rst_n)
         $past(i_rst_n) |-> (i_imem_addr == $past(i_imem_addr) + 16'd1);
   endproperty

   a_dmem_we_known: assert property (p_dmem_we_known)
      else begin
         $error("o_dmem_we is unknown after reset");
         n_fail++;
      end
   a_no_write_on_stall: assert property (p_no_write_on_stall)
      else begin
         $error("register or nzp write on a stall cycle");
         n_fail++;
      end
   a_pc_steps: assert property (p_pc_steps)
      else begin
         $error("o_imem_addr did not advance by one");
         n_fail++;
      end

endmodule

//--- verif/lc4_tb.sv
// LC4 pipeline testbench
// random program from the supported subset on a ROM at the fetch port
// a reference model of the architectural state is checked against the retire trace
`include "lc4_params.svh"

module lc4_tb;
   import lc4_isa_pkg::*;

   localparam int PROG_LEN = 64;

   logic                   gwe;
   logic                   i_rst_n;
   logic [`LC4_WORD_W-1:0] i_imem_insn;
   logic [`LC4_WORD_W-1:0] o_imem_addr;
   logic                   o_dmem_we;
   logic [`LC4_WORD_W-1:0] o_dmem_addr;
   logic [`LC4_WORD_W-1:0] o_dmem_wdata;
   logic                   o_wb_stall;
   logic [`LC4_WORD_W-1:0] o_wb_pc;
   logic [`LC4_WORD_W-1:0] o_wb_insn;
   logic                   o_wb_rf_we;
   logic [`LC4_RSEL_W-1:0] o_wb_rf_wsel;
   logic [`LC4_WORD_W-1:0] o_wb_rf_data;
   logic                   o_wb_nzp_we;
   logic [2:0]             o_wb_nzp;

   lc4_insn_u prog [PROG_LEN];       // program image at 8200h upward
   integer    seed = 32'h554614b1;
   int        n_err = 0;

   lc4_clkgen u_clkgen (.gwe(gwe), .o_rst_n(i_rst_n));

   lc4_processor i_dut (.*);

   bind lc4_processor lc4_pipe_assert u_pipe_assert (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_imem_addr(o_imem_addr), .i_dmem_we(o_dmem_we),
      .i_wb_stall(o_wb_stall), .i_wb_rf_we(o_wb_rf_we), .i_wb_nzp_we(o_wb_nzp_we)
   );

   task automatic stop_on_fail();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic insn_check(input string name, input lc4_insn_u got, input lc4_insn_u exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         n_err++;
         stop_on_fail();
      end
   endtask

   task automatic word_check(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         n_err++;
         stop_on_fail();
      end
   endtask

   task automatic field_check(input string name, input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         n_err++;
         stop_on_fail();
      end
   endtask

   task automatic flag_check(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         n_err++;
         stop_on_fail();
      end
   endtask

   // one instruction applied to the architectural state by the ISA rules
   function automatic void lc4_ref_step(
      input  logic [`LC4_NREG-1:0][`LC4_WORD_W-1:0] regs,
      input  logic [2:0]  nzp_in,
      input  lc4_insn_u   insn,
      output logic        rf_we,
      output logic [2:0]  wsel,
      output logic [15:0] wdata,
      output logic        nzp_we,
      output logic [2:0]  nzp_out,
      output logic        st_we,
      output logic [15:0] st_addr,
      output logic [15:0] st_data
   );
      logic [15:0] w;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm5;
      w       = insn;
      a       = regs[w[8:6]];
      b       = regs[w[2:0]];
      imm5    = {{11{w[4]}}, w[4:0]};
      rf_we   = 1'b0;
      wsel    = w[11:9];
      wdata   = '0;
      st_we   = 1'b0;
      st_addr = '0;
      st_data = '0;
      case (w[15:12])
         `LC4_OP_ARITH: begin
            rf_we = w[5] || (w[5:3] == `LC4_SUB_ADD) || (w[5:3] == `LC4_SUB_SUB);
            if (w[5]) wdata = a + imm5;
            else if (w[5:3] == `LC4_SUB_SUB) wdata = a - b;
            else wdata = a + b;                 // mul/div have rf_we low anyway
         end
         `LC4_OP_LOGIC: begin
            rf_we = 1'b1;                       // every logic form is kept
            if (w[5]) wdata = a & imm5;
            else if (w[5:3] == `LC4_SUB_NOT) wdata = ~a;
            else if (w[5:3] == `LC4_SUB_OR) wdata = a | b;
            else if (w[5:3] == `LC4_SUB_XOR) wdata = a ^ b;
            else wdata = a & b;
         end
         `LC4_OP_CONST: begin
            rf_we = 1'b1;
            wdata = {{7{w[8]}}, w[8:0]};
         end
         `LC4_OP_STR: begin
            st_we   = 1'b1;
            st_addr = a + {{10{w[5]}}, w[5:0]};
            st_data = regs[w[11:9]];            // data register sits in the rd slot
         end
         default: ;
      endcase
      nzp_we = rf_we;
      if (!rf_we) nzp_out = nzp_in;
      else if (wdata[15]) nzp_out = `LC4_NZP_NEG;
      else if (wdata == 16'h0000) nzp_out = `LC4_NZP_ZERO;
      else nzp_out = `LC4_NZP_POS;
   endfunction

   function automatic lc4_insn_u rom_word(input logic [15:0] addr);
      logic [15:0] offs;
      offs = addr - `LC4_RESET_PC;
      if (offs < PROG_LEN) return prog[offs];
      return '0;                                // only bubbles past the end of the program
   endfunction

   task automatic build_program();
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [8:0] imm;
      int         kind;
      // the fixed head has dependences at distance 1, 2 and 3
      prog[0] = {`LC4_OP_CONST, 3'd0, 9'h1fd};                  // r0 = -3
      prog[1] = {`LC4_OP_ARITH, 3'd1, 3'd0, `LC4_SUB_ADD, 3'd0}; // r0 over MX
      prog[2] = {`LC4_OP_ARITH, 3'd2, 3'd0, `LC4_SUB_ADD, 3'd1}; // r0 by WX and r1 by MX
      prog[3] = {`LC4_OP_ARITH, 3'd3, 3'd0, `LC4_SUB_SUB, 3'd2}; // r0 through WD
      prog[4] = {`LC4_OP_STR, 3'd3, 3'd1, 6'h02};                // data by MX and base by WD
      for (int k = 5; k < PROG_LEN; k++) begin
         rd   = 3'($unsigned($random(seed)) % 4);   // only r0..r3 so destinations repeat
         rs   = 3'($unsigned($random(seed)) % 4);
         rt   = 3'($unsigned($random(seed)) % 4);
         imm  = 9'($random(seed));
         kind = $unsigned($random(seed)) % 15;
         case (kind)
            0:       prog[k] = {`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt};
            1:       prog[k] = {`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt};
            2:       prog[k] = {`LC4_OP_ARITH, rd, rs, 1'b1, imm[4:0]};
            3:       prog[k] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt};
            4:       prog[k] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_OR, rt};
            5:       prog[k] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_XOR, rt};
            6:       prog[k] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_NOT, rt};
            7:       prog[k] = {`LC4_OP_LOGIC, rd, rs, 1'b1, imm[4:0]};
            8, 9:    prog[k] = {`LC4_OP_CONST, rd, imm};
            10, 11:  prog[k] = {`LC4_OP_STR, rt, rs, imm[5:0]};
            12:      prog[k] = '0;                                  // bubble
            13:      prog[k] = {4'b1010, rd, rs, imm[5:0]};         // unsupported shift
            default: prog[k] = {`LC4_OP_ARITH, rd, rs, 3'b001, rt}; // unsupported MUL
         endcase
      end
   endtask

   initial begin
      i_imem_insn = '0;
      build_program();
   end

   // the instruction ROM answers the fetch address 1 unit after each edge
   always @(posedge gwe) begin
      #1;
      i_imem_insn = rom_word(o_imem_addr);
   end

   // a failed bound assertion ends the run as well
   always @(negedge gwe) begin
      if (i_dut.u_pipe_assert.n_fail != 0) begin
         $display("a bound assertion on the pipeline failed");
         stop_on_fail();
      end
   end

   initial begin : compare_proc
      logic [`LC4_NREG-1:0][`LC4_WORD_W-1:0] arch_regs;
      logic [2:0]  arch_nzp;
      logic        e_we;
      logic [2:0]  e_sel;
      logic [15:0] e_data;
      logic        e_nzp_we;
      logic [2:0]  e_nzp;
      logic        e_st;
      logic [15:0] e_addr;
      logic [15:0] e_wdata;
      int          waited;
      arch_regs = '0;
      arch_nzp  = '0;
      waited    = 0;
      while (i_rst_n !== 1'b1 && waited < 200) begin
         @(negedge gwe);
         waited++;
      end
      if (i_rst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         stop_on_fail();
      end
      waited = 0;                               // edges since release
      while (o_wb_stall !== 1'b0 && waited < 200) begin
         word_check("o_imem_addr", o_imem_addr, 16'(`LC4_RESET_PC + waited));
         @(negedge gwe);
         waited++;
      end
      if (o_wb_stall !== 1'b0) begin
         $display("timeout: no instruction retired after reset");
         stop_on_fail();
      end
      word_check("cycles to first retire", 16'(waited), 16'd4);
      for (int k = 0; k < PROG_LEN; k++) begin
         if (k > 0) @(negedge gwe);
         word_check("o_imem_addr", o_imem_addr, 16'(`LC4_RESET_PC + k + 4));
         lc4_ref_step(arch_regs, arch_nzp, prog[k], e_we, e_sel, e_data, e_nzp_we, e_nzp,
                      e_st, e_addr, e_wdata);
         flag_check("o_wb_stall", o_wb_stall, prog[k] == '0);
         word_check("o_wb_pc", o_wb_pc, 16'(`LC4_RESET_PC + k));
         insn_check("o_wb_insn", o_wb_insn, prog[k]);
         flag_check("o_wb_rf_we", o_wb_rf_we, e_we);
         if (e_we) begin
            field_check("o_wb_rf_wsel", o_wb_rf_wsel, e_sel);
            word_check("o_wb_rf_data", o_wb_rf_data, e_data);
            arch_regs[e_sel] = e_data;
         end
         flag_check("o_wb_nzp_we", o_wb_nzp_we, e_nzp_we);
         field_check("o_wb_nzp", o_wb_nzp, e_nzp);
         arch_nzp = e_nzp;
         // the memory stage holds the next word and its store shows one cycle before its trace
         lc4_ref_step(arch_regs, arch_nzp, rom_word(16'(`LC4_RESET_PC + k + 1)), e_we, e_sel,
                      e_data, e_nzp_we, e_nzp, e_st, e_addr, e_wdata);
         flag_check("o_dmem_we", o_dmem_we, e_st);
         if (e_st) begin
            word_check("o_dmem_addr", o_dmem_addr, e_addr);
            word_check("o_dmem_wdata", o_dmem_wdata, e_wdata);
         end
      end
      if (n_err == 0 && i_dut.u_pipe_assert.n_fail == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_on_fail();
      end
   end

endmodule

//--- flist.f
+incdir+logic
logic/lc4_isa_pkg.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_execute.sv
logic/lc4_processor.sv
verif/lc4_clkgen.sv
verif/lc4_pipe_assert.sv
verif/lc4_tb.sv

//--- Bender.yml
package:
  name: lc4_pipeline

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lc4_isa_pkg.sv
      - logic/lc4_decoder.sv
      - logic/lc4_regfile.sv
      - logic/lc4_execute.sv
      - logic/lc4_processor.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/lc4_clkgen.sv
      - verif/lc4_pipe_assert.sv
      - verif/lc4_tb.sv
